// ==== design/glb_bank_pkg.sv ====
package glb_bank_pkg;

    // bank geometry
    localparam int BANK_ADDR_WIDTH      = 12;
    localparam int BANK_DATA_WIDTH      = 64;
    // byte offset inside a 64-bit word
    localparam int BANK_BYTE_OFFSET     = 3;
    // host side moves half a word at a time
    localparam int CFG_DATA_WIDTH       = 32;
    // word index, 512 words
    localparam int BANK_WORD_ADDR_WIDTH = BANK_ADDR_WIDTH - BANK_BYTE_OFFSET;

    // packet write, bit_sel is a per-bit write mask
    typedef struct packed {
        logic                       en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [BANK_DATA_WIDTH-1:0] data;
        logic [BANK_DATA_WIDTH-1:0] bit_sel;
    } packet_wr_req_t;

    // packet read request
    typedef struct packed {
        logic                       en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
    } packet_rd_req_t;

    // packet read result, data held between responses
    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0] data;
        logic                       valid;
    } packet_rd_rsp_t;

    // one config access, single address per apb transfer
    typedef struct packed {
        logic                       wr_en;
        logic                       rd_en;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0]  wr_data;
    } cfg_req_t;

    // config read result
    typedef struct packed {
        logic [CFG_DATA_WIDTH-1:0] rd_data;
        logic                      rd_data_valid;
    } cfg_rsp_t;

    // single memory access after arbitration
    typedef struct packed {
        logic                            rd_en;
        logic                            wr_en;
        logic [BANK_WORD_ADDR_WIDTH-1:0] word_addr;
        logic [BANK_DATA_WIDTH-1:0]      data;
        logic [BANK_DATA_WIDTH-1:0]      bit_sel;
    } mem_req_t;

endpackage

// ==== design/glb_cfg_apb_slave.sv ====
`timescale 1ns/1ps

module glb_cfg_apb_slave
    import glb_bank_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,

    // apb slave side
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [BANK_ADDR_WIDTH-1:0] paddr,
    input  logic [CFG_DATA_WIDTH-1:0]  pwdata,
    output logic [CFG_DATA_WIDTH-1:0]  prdata,
    output logic                       pready,

    // toward the bank controller
    output cfg_req_t                   cfg_req,
    input  cfg_rsp_t                   cfg_rsp
);

    // access phase of any transfer
    logic access;
    // read already sent, now waiting for data
    logic rd_issued;
    // read access that is only waiting
    logic read_wait;

    assign access    = psel & penable;
    assign read_wait = access & ~pwrite & rd_issued;

    // requests last exactly one cycle
    // write goes out in its first access cycle
    // read goes out once, then the slave waits
    assign cfg_req = '{
        wr_en:   access & pwrite,
        rd_en:   access & ~pwrite & ~rd_issued,
        addr:    paddr,
        wr_data: pwdata
    };

    // write completes immediately
    // read completes when the controller returns valid
    assign pready = (access & pwrite) | (read_wait & cfg_rsp.rd_data_valid);

    // controller holds its last half-word, so pass straight through
    assign prdata = cfg_rsp.rd_data;

    // read issued flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_issued <= 1'b0;
        end else if (access && pready) begin
            // transfer done, ready for the next one
            rd_issued <= 1'b0;
        end else if (cfg_req.rd_en) begin
            rd_issued <= 1'b1;
        end
    end

    // returned data only shows up while a read is parked in its access phase
    a_rd_valid_in_wait: assert property (
        @(posedge clk) disable iff (reset)
        cfg_rsp.rd_data_valid |-> read_wait
    ) else $error("config read data returned with no read waiting");

    // controller answers a config read exactly two cycles later
    a_rd_latency: assert property (
        @(posedge clk) disable iff (reset)
        cfg_req.rd_en |-> ##2 cfg_rsp.rd_data_valid
    ) else $error("config read data not returned after two cycles");

endmodule

// ==== design/glb_bank_ctrl.sv ====
`timescale 1ns/1ps

module glb_bank_ctrl
    import glb_bank_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,

    // config port
    input  cfg_req_t                   cfg_req,
    output cfg_rsp_t                   cfg_rsp,

    // packet port
    input  packet_wr_req_t             packet_wr,
    input  packet_rd_req_t             packet_rd,
    output packet_rd_rsp_t             packet_rd_rsp,

    // memory side
    output mem_req_t                   mem_req,
    input  logic [BANK_DATA_WIDTH-1:0] mem_rd_data
);

    // address bit 2 picks the upper half
    localparam int HALF_SEL_BIT = BANK_BYTE_OFFSET - 1;
    // zero fill for the unused half
    localparam int PAD_WIDTH    = BANK_DATA_WIDTH - CFG_DATA_WIDTH;

    // winner of this cycle
    mem_req_t                        req_next;
    logic                            pkt_rd_issue;
    logic                            cfg_rd_issue;

    // registered memory request
    logic                            mem_rd_en_q;
    logic                            mem_wr_en_q;
    logic [BANK_WORD_ADDR_WIDTH-1:0] mem_word_addr_q;
    logic [BANK_DATA_WIDTH-1:0]      mem_data_q;
    logic [BANK_DATA_WIDTH-1:0]      mem_bit_sel_q;

    // in-flight read tags, bit 1 is the cycle data returns
    logic [1:0]                      pkt_rd_tag;
    logic [1:0]                      cfg_rd_tag;
    logic [1:0]                      cfg_half_tag;

    // held read values
    logic [BANK_DATA_WIDTH-1:0]      pkt_rd_data_q;
    logic [CFG_DATA_WIDTH-1:0]       cfg_rd_data_q;
    logic [CFG_DATA_WIDTH-1:0]       cfg_half_word;

    // fixed priority: cfg wr, cfg rd, pkt wr, pkt rd
    // losing packet requests are dropped
    always_comb begin
        req_next     = '0;
        pkt_rd_issue = 1'b0;
        cfg_rd_issue = 1'b0;
        if (cfg_req.wr_en) begin
            req_next.wr_en     = 1'b1;
            req_next.word_addr = cfg_req.addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
            // place the half-word and mask only that half
            if (cfg_req.addr[HALF_SEL_BIT]) begin
                req_next.data    = {cfg_req.wr_data, {PAD_WIDTH{1'b0}}};
                req_next.bit_sel = {{CFG_DATA_WIDTH{1'b1}}, {PAD_WIDTH{1'b0}}};
            end else begin
                req_next.data    = {{PAD_WIDTH{1'b0}}, cfg_req.wr_data};
                req_next.bit_sel = {{PAD_WIDTH{1'b0}}, {CFG_DATA_WIDTH{1'b1}}};
            end
        end else if (cfg_req.rd_en) begin
            req_next.rd_en     = 1'b1;
            req_next.word_addr = cfg_req.addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
            cfg_rd_issue       = 1'b1;
        end else if (packet_wr.en) begin
            req_next.wr_en     = 1'b1;
            req_next.word_addr = packet_wr.addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
            req_next.data      = packet_wr.data;
            req_next.bit_sel   = packet_wr.bit_sel;
        end else if (packet_rd.en) begin
            req_next.rd_en     = 1'b1;
            req_next.word_addr = packet_rd.addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
            pkt_rd_issue       = 1'b1;
        end
    end

    // request enables
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_rd_en_q <= 1'b0;
            mem_wr_en_q <= 1'b0;
        end else begin
            mem_rd_en_q <= req_next.rd_en;
            mem_wr_en_q <= req_next.wr_en;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        mem_word_addr_q <= req_next.word_addr;
        mem_data_q      <= req_next.data;
        mem_bit_sel_q   <= req_next.bit_sel;
    end

    assign mem_req = '{
        rd_en:     mem_rd_en_q,
        wr_en:     mem_wr_en_q,
        word_addr: mem_word_addr_q,
        data:      mem_data_q,
        bit_sel:   mem_bit_sel_q
    };

    // two stages, one for mem_req and one for the sram read register
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_rd_tag   <= 2'b00;
            cfg_rd_tag   <= 2'b00;
            cfg_half_tag <= 2'b00;
        end else begin
            pkt_rd_tag   <= {pkt_rd_tag[0], pkt_rd_issue};
            cfg_rd_tag   <= {cfg_rd_tag[0], cfg_rd_issue};
            cfg_half_tag <= {cfg_half_tag[0], cfg_req.addr[HALF_SEL_BIT]};
        end
    end

    // half-word for the host
    assign cfg_half_word = cfg_half_tag[1] ? mem_rd_data[CFG_DATA_WIDTH +: CFG_DATA_WIDTH]
                                           : mem_rd_data[0 +: CFG_DATA_WIDTH];

    // hold last returned values
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pkt_rd_data_q <= '0;
            cfg_rd_data_q <= '0;
        end else begin
            if (pkt_rd_tag[1]) begin
                pkt_rd_data_q <= mem_rd_data;
            end
            if (cfg_rd_tag[1]) begin
                cfg_rd_data_q <= cfg_half_word;
            end
        end
    end

    assign packet_rd_rsp = '{
        data:  pkt_rd_tag[1] ? mem_rd_data : pkt_rd_data_q,
        valid: pkt_rd_tag[1]
    };

    assign cfg_rsp = '{
        rd_data:       cfg_rd_tag[1] ? cfg_half_word : cfg_rd_data_q,
        rd_data_valid: cfg_rd_tag[1]
    };

    // one access per cycle
    a_mem_one_op: assert property (
        @(posedge clk) disable iff (reset)
        !(mem_req.rd_en && mem_req.wr_en)
    ) else $error("memory read and write issued together");

    // a returning read belongs to exactly one client
    a_rsp_one_owner: assert property (
        @(posedge clk) disable iff (reset)
        !(cfg_rsp.rd_data_valid && packet_rd_rsp.valid)
    ) else $error("read data routed to both clients");

endmodule

// ==== design/glb_bank_sram.sv ====
`timescale 1ns/1ps

module glb_bank_sram
    import glb_bank_pkg::*;
(
    input  logic                       clk,

    // one access per cycle from the controller
    input  mem_req_t                   mem_req,

    // registered read word
    output logic [BANK_DATA_WIDTH-1:0] rd_data
);

    // number of words in the bank
    localparam int MEM_DEPTH = 2 ** BANK_WORD_ADDR_WIDTH;

    // behavioral storage, stands in for a macro
    logic [BANK_DATA_WIDTH-1:0] mem [MEM_DEPTH];

    // word currently addressed
    logic [BANK_DATA_WIDTH-1:0] cur_word;
    // word after the masked merge
    logic [BANK_DATA_WIDTH-1:0] merged_word;

    assign cur_word = mem[mem_req.word_addr];

    // set mask bits take new data, others keep old contents
    assign merged_word = (cur_word & ~mem_req.bit_sel) | (mem_req.data & mem_req.bit_sel);

    // masked write
    always_ff @(posedge clk) begin
        if (mem_req.wr_en) begin
            mem[mem_req.word_addr] <= merged_word;
        end
    end

    // read lands one edge after the request
    // output keeps its value when no read is issued
    always_ff @(posedge clk) begin
        if (mem_req.rd_en) begin
            rd_data <= cur_word;
        end
    end

    // single port, never both at once
    a_single_port: assert property (
        @(posedge clk)
        !(mem_req.rd_en && mem_req.wr_en)
    ) else $error("sram read and write in the same cycle");

endmodule

// ==== design/glb_bank.sv ====
`timescale 1ns/1ps

module glb_bank
    import glb_bank_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,

    // apb configuration port, no pslverr
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [BANK_ADDR_WIDTH-1:0] paddr,
    input  logic [CFG_DATA_WIDTH-1:0]  pwdata,
    output logic [CFG_DATA_WIDTH-1:0]  prdata,
    output logic                       pready,

    // packet streaming port
    input  packet_wr_req_t             packet_wr,
    input  packet_rd_req_t             packet_rd,
    output packet_rd_rsp_t             packet_rd_rsp
);

    // apb slave <-> controller
    cfg_req_t                   cfg_req;
    cfg_rsp_t                   cfg_rsp;

    // controller <-> memory
    mem_req_t                   mem_req;
    logic [BANK_DATA_WIDTH-1:0] mem_rd_data;

    // host access, apb to single-cycle requests
    glb_cfg_apb_slave i_cfg_apb_slave (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .cfg_req (cfg_req),
        .cfg_rsp (cfg_rsp)
    );

    // arbitration and read return
    glb_bank_ctrl i_bank_ctrl (
        .clk           (clk),
        .reset         (reset),
        .cfg_req       (cfg_req),
        .cfg_rsp       (cfg_rsp),
        .packet_wr     (packet_wr),
        .packet_rd     (packet_rd),
        .packet_rd_rsp (packet_rd_rsp),
        .mem_req       (mem_req),
        .mem_rd_data   (mem_rd_data)
    );

    // storage, 512 x 64
    glb_bank_sram i_bank_sram (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_data (mem_rd_data)
    );

endmodule

// ==== tests/tb_glb_bank.sv ====
`timescale 1ns/1ps

module tb_glb_bank
    import glb_bank_pkg::*;
();

    localparam int CLK_HALF       = 20;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int MAX_OPS        = 64;
    localparam int VEC_COLS       = 5;
    // random traffic stays in a 16-word window
    localparam int RAND_BASE_WORD = 256;
    // operation codes of the vector file
    localparam logic [7:0] OP_END        = 8'h00;
    localparam logic [7:0] OP_APB_WR     = 8'h01;
    localparam logic [7:0] OP_APB_RD     = 8'h02;
    localparam logic [7:0] OP_PKT_WR     = 8'h03;
    localparam logic [7:0] OP_PKT_RD     = 8'h04;
    localparam logic [7:0] OP_PKT_APB_WR = 8'h05;
    localparam logic [7:0] OP_RANDOM     = 8'h06;

    logic                       clk;
    logic                       reset;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [BANK_ADDR_WIDTH-1:0] paddr;
    logic [CFG_DATA_WIDTH-1:0]  pwdata;
    logic [CFG_DATA_WIDTH-1:0]  prdata;
    logic                       pready;
    packet_wr_req_t             packet_wr;
    packet_rd_req_t             packet_rd;
    packet_rd_rsp_t             packet_rd_rsp;

    logic [63:0] vec [0:MAX_OPS*VEC_COLS-1];
    // reference copy of the bank
    logic [BANK_DATA_WIDTH-1:0] model [0:(2**BANK_WORD_ADDR_WIDTH)-1];
    logic [15:0] lfsr;
    int          cyc;
    logic [63:0] last_data;
    // packet reads in flight, due cycle and expected word
    int          due_q[$];
    logic [63:0] exp_q[$];
    string       name_q[$];

    glb_bank i_dut (
        .clk           (clk),
        .reset         (reset),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .packet_wr     (packet_wr),
        .packet_rd     (packet_rd),
        .packet_rd_rsp (packet_rd_rsp)
    );

    always #(CLK_HALF) clk = ~clk;

    task automatic fail_run();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        fail_run();
    endtask

    // galois form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // half-word of the reference copy, bit 2 picks the upper half
    function automatic logic [31:0] model_half(input logic [11:0] addr);
        logic [8:0] w;
        w = addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
        return addr[2] ? model[w][63:32] : model[w][31:0];
    endfunction

    // one lfsr step per bit taken
    task automatic take_random_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    // falling edge: check packet response, then idle all inputs
    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            check_value({name_q[0], " valid"}, 64'd1, 64'(packet_rd_rsp.valid));
            check_value(name_q[0], exp_q[0], packet_rd_rsp.data);
            last_data = exp_q[0];
            due_q.delete(0);
            exp_q.delete(0);
            name_q.delete(0);
        end else begin
            check_value("packet valid while idle", 64'd0, 64'(packet_rd_rsp.valid));
            // data must hold the last response
            check_value("packet data held", last_data, packet_rd_rsp.data);
        end
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        packet_wr.en = 1'b0;
        packet_rd.en = 1'b0;
    endtask

    task automatic drive_apb(input logic access, input logic wr,
                             input logic [11:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = access;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
    endtask

    // first access cycle already driven, sample pready mid low phase
    task automatic finish_transfer(input logic wr, input logic [11:0] addr,
                                   input logic [31:0] data, output int n_access);
        n_access = 1;
        #(CLK_HALF/2);
        while (pready !== 1'b1) begin
            if (n_access >= TIMEOUT_CYCLES) report_timeout("pready");
            next_cycle();
            drive_apb(1'b1, wr, addr, data);
            n_access++;
            #(CLK_HALF/2);
        end
    endtask

    task automatic packet_write(input logic [11:0] addr, input logic [63:0] data,
                                input logic [63:0] mask);
        logic [8:0] w;
        w = addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
        next_cycle();
        packet_wr.en      = 1'b1;
        packet_wr.addr    = addr;
        packet_wr.data    = data;
        packet_wr.bit_sel = mask;
        // only the selected bits take the new value
        for (int b = 0; b < BANK_DATA_WIDTH; b++) begin
            if (mask[b]) begin
                model[w][b] = data[b];
            end
        end
    endtask

    // response is due two cycles after the request
    task automatic packet_read(input logic [11:0] addr, input string name);
        next_cycle();
        packet_rd.en   = 1'b1;
        packet_rd.addr = addr;
        due_q.push_back(cyc + 2);
        exp_q.push_back(model[addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET]]);
        name_q.push_back(name);
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic with_pkt, input logic [63:0] pkt_data,
                             input logic [63:0] pkt_mask);
        int         n_access;
        logic [8:0] w;
        w = addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
        next_cycle();
        drive_apb(1'b0, 1'b1, addr, data);
        next_cycle();
        drive_apb(1'b1, 1'b1, addr, data);
        if (with_pkt) begin
            // loses to the config write, never reaches the model
            packet_wr.en      = 1'b1;
            packet_wr.addr    = addr;
            packet_wr.data    = pkt_data;
            packet_wr.bit_sel = pkt_mask;
        end
        finish_transfer(1'b1, addr, data, n_access);
        check_value($sformatf("apb write %h access cycles", addr), 64'd1, 64'(n_access));
        if (addr[2]) begin
            model[w][63:32] = data;
        end else begin
            model[w][31:0] = data;
        end
    endtask

    task automatic apb_read(input logic [11:0] addr);
        int          n_access;
        logic [31:0] exp_half;
        exp_half = model_half(addr);
        next_cycle();
        drive_apb(1'b0, 1'b0, addr, 32'd0);
        next_cycle();
        drive_apb(1'b1, 1'b0, addr, 32'd0);
        finish_transfer(1'b0, addr, 32'd0, n_access);
        check_value($sformatf("apb read %h access cycles", addr), 64'd3, 64'(n_access));
        check_value($sformatf("apb read %h data", addr), 64'(exp_half), 64'(prdata));
    endtask

    // full-mask writes, packet and config reads, reads only hit words already written
    task automatic random_traffic(input int count);
        logic [63:0] bit_v;
        logic [63:0] idx_v;
        logic [63:0] sel_v;
        logic [63:0] data_v;
        logic [15:0] written;
        logic [11:0] addr;
        written = '0;
        for (int i = 0; i < count; i++) begin
            take_random_bits(1, bit_v);
            take_random_bits(4, idx_v);
            addr = 12'((RAND_BASE_WORD + int'(idx_v[3:0])) << BANK_BYTE_OFFSET);
            if (bit_v[0] && written[idx_v[3:0]]) begin
                take_random_bits(2, sel_v);
                if (sel_v[0]) begin
                    // config read moves the sram output away from the last packet word
                    apb_read({addr[11:3], sel_v[1], 2'b00});
                end else begin
                    packet_read(addr, $sformatf("random read %h", addr));
                end
            end else begin
                take_random_bits(64, data_v);
                packet_write(addr, data_v, '1);
                written[idx_v[3:0]] = 1'b1;
            end
            // sometimes an idle gap
            take_random_bits(1, bit_v);
            if (bit_v[0]) next_cycle();
        end
    endtask

    task automatic drain_reads();
        int n;
        n = 0;
        while (due_q.size() > 0) begin
            if (n >= TIMEOUT_CYCLES) report_timeout("packet read valid");
            next_cycle();
            n++;
        end
    endtask

    initial begin
        int          k;
        logic        done;
        logic [7:0]  op;
        logic [11:0] addr;
        logic [63:0] data;
        logic [63:0] mask;
        logic [63:0] expv;
        clk       = 1'b0;
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        packet_wr = '0;
        packet_rd = '0;
        lfsr      = 16'd51;
        cyc       = 0;
        last_data = '0;
        $readmemh("tests/glb_bank_vectors.txt", vec);
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(CLK_HALF/2);
        check_value("pready after reset", 64'd0, 64'(pready));
        check_value("packet valid after reset", 64'd0, 64'(packet_rd_rsp.valid));
        done = 1'b0;
        k    = 0;
        while (!done) begin
            if (k >= MAX_OPS) begin
                $display("vector file has no end marker");
                fail_run();
            end
            op   = vec[k*VEC_COLS][7:0];
            addr = vec[k*VEC_COLS+1][11:0];
            data = vec[k*VEC_COLS+2];
            mask = vec[k*VEC_COLS+3];
            expv = vec[k*VEC_COLS+4];
            case (op)
                OP_APB_WR:     apb_write(addr, data[31:0], 1'b0, '0, '0);
                OP_APB_RD: begin
                    check_value($sformatf("apb read %h vector vs model", addr),
                                64'(expv[31:0]), 64'(model_half(addr)));
                    apb_read(addr);
                end
                OP_PKT_WR:     packet_write(addr, data, mask);
                OP_PKT_RD: begin
                    check_value($sformatf("packet read %h vector vs model", addr), expv,
                                model[addr[BANK_ADDR_WIDTH-1:BANK_BYTE_OFFSET]]);
                    packet_read(addr, $sformatf("packet read %h", addr));
                end
                OP_PKT_APB_WR: apb_write(addr, data[31:0], 1'b1, data, mask);
                OP_RANDOM:     random_traffic(int'(data[15:0]));
                OP_END:        done = 1'b1;
                default: begin
                    $display("unknown operation code %h in vector file", op);
                    fail_run();
                end
            endcase
            k++;
        end
        drain_reads();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tests/glb_bank_vectors.txt ====
// columns: op addr data mask expected, all hex
// op 1 apb wr, 2 apb rd, 3 pkt wr, 4 pkt rd, 5 pkt wr with apb wr, 6 random (data = count), 0 end
// full-word round trip, reads back to back
3 010 0123456789abcdef ffffffffffffffff 0
3 018 fedcba9876543210 ffffffffffffffff 0
3 020 a5a5a5a55a5a5a5a ffffffffffffffff 0
4 010 0 0 0123456789abcdef
4 018 0 0 fedcba9876543210
4 020 0 0 a5a5a5a55a5a5a5a
// partial write masks
3 010 ffffffffffffffff 00000000ffff0000 0
4 010 0 0 01234567ffffcdef
3 018 0000000000000000 ff000000000000ff 0
4 018 0 0 00dcba9876543200
// config half-words, bit 2 picks the upper half
1 020 11223344 0 0
1 024 55667788 0 0
4 020 0 0 5566778811223344
2 020 0 0 11223344
2 024 0 0 55667788
// priority, packet writes in the apb access cycle are dropped
3 028 0000000000000000 ffffffffffffffff 0
5 028 deadbeefcafef00d ffffffffffffffff 0
5 02c 1111111122222222 ffffffffffffffff 0
4 028 0 0 22222222cafef00d
2 02c 0 0 22222222
// random traffic from the lfsr
6 000 28 0 0
0 0 0 0 0

// ==== glb_bank.f ====
design/glb_bank_pkg.sv
design/glb_cfg_apb_slave.sv
design/glb_bank_ctrl.sv
design/glb_bank_sram.sv
design/glb_bank.sv
tests/tb_glb_bank.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_glb_bank
FILELIST  = glb_bank.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Result: FAILED
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
